//--- processor.f
+incdir+.
isaPkg.sv
pipePkg.sv
fetchStage.sv
registerFile.sv
decodeStage.sv
executeStage.sv
hazardUnit.sv
memoryStage.sv
processor.sv
processorTb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = processorTb
FILELIST = processor.f
OBJDIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

//--- processorTb.sv
`timescale 1ns/1ps
`include "pipeline_macros.svh"

module processorTb;

    import isaPkg::*;

    localparam int ResetCycles = 16;
    localparam int WaitLimit   = 400;
    localparam int StepLimit   = 1000;

    logic     Clock = 1'b0;
    logic     nReset = 1'b0;
    instrAddr InstrAddr;
    dataWord  InstrMem;
    instrAddr MemAddr;
    logic     MemRead;
    logic     MemWrite;
    dataWord  WriteData;
    dataWord  MemData = '0;
    regAddr   RegAddr = '0;
    dataWord  RegData;
    logic     nStall;
    logic     JBFlush;

    dataWord  imem [64];
    dataWord  dmem [64];
    dataWord  goldMem [64];
    dataWord  goldRegs [32];
    logic     goldWritten [32];
    instrAddr expStoreAddr [$];
    dataWord  expStoreData [$];
    instrAddr expTargets [$];
    int       expStalls = 0;
    int       progLen = 0;
    int       storeIdx = 0;
    int       jbCount = 0;
    int       stallCycles = 0;
    logic     jbPending = 1'b0;
    logic     stallPending = 1'b0;
    integer   seed;

    always #4 Clock = ~Clock;

    processor UUT (
        .Clock     (Clock),
        .nReset    (nReset),
        .InstrAddr (InstrAddr),
        .InstrMem  (InstrMem),
        .MemAddr   (MemAddr),
        .MemRead   (MemRead),
        .MemWrite  (MemWrite),
        .WriteData (WriteData),
        .MemData   (MemData),
        .RegAddr   (RegAddr),
        .RegData   (RegData),
        .nStall    (nStall),
        .JBFlush   (JBFlush)
    );

    // ----------------------------------------
    // Memory models
    // ----------------------------------------

    assign InstrMem = imem[InstrAddr[7:2]];

    // Load data shows up one cycle after MemRead
    always @(posedge Clock) begin
        if (MemRead) begin
            MemData <= dmem[MemAddr[7:2]];
        end
        if (MemWrite) begin
            dmem[MemAddr[7:2]] = WriteData;
        end
    end

    // ----------------------------------------
    // Failure reporting
    // ----------------------------------------

    task automatic mismatch(string testName, dataWord expected, dataWord actual);
        $display("FAILED %s: expected %h, actual %h", testName, expected, actual);
        $display("Simulation FAILED");
        $fatal(1, "value mismatch");
    endtask

    task automatic abortWithMessage(string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "run stopped");
    endtask

    // ----------------------------------------
    // Program and golden model
    // ----------------------------------------

    function automatic dataWord rTypeWord(functE fn, int rd, int rs, int rt);
        return {RType, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic dataWord iTypeWord(opcodeE op, int rt, int rs, int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    task automatic emit(dataWord word);
        imem[progLen[5:0]] = word;
        progLen++;
    endtask

    task automatic buildProgram();
        int i;
        for (i = 0; i < 64; i++) begin
            imem[i[5:0]] = '0;
        end
        emit(iTypeWord(Addi, 1, 0, 5));
        emit(iTypeWord(Addi, 2, 1, 7));
        emit(rTypeWord(Add, 3, 1, 2));
        emit(rTypeWord(Sub, 4, 3, 1));
        emit(rTypeWord(And, 5, 4, 2));
        emit(rTypeWord(Or, 6, 5, 3));
        emit(rTypeWord(Slt, 7, 4, 3));
        emit(rTypeWord(Slt, 8, 3, 4));
        emit(iTypeWord(Addi, 9, 0, -3));
        emit(rTypeWord(Slt, 10, 9, 1));
        emit(iTypeWord(Addi, 11, 0, 64));
        emit(iTypeWord(Sw, 3, 11, 0));
        emit(iTypeWord(Sw, 9, 11, 4));
        // Load-use pairs
        emit(iTypeWord(Lw, 12, 11, 8));
        emit(rTypeWord(Add, 13, 12, 1));
        emit(iTypeWord(Lw, 14, 11, 0));
        emit(iTypeWord(Addi, 15, 14, 1));
        emit(iTypeWord(Sw, 13, 11, 12));
        // Untaken, then taken over two instructions
        emit(iTypeWord(Beq, 2, 1, 5));
        emit(iTypeWord(Beq, 3, 3, 2));
        emit(iTypeWord(Addi, 5, 0, 99));
        emit(iTypeWord(Sw, 5, 11, 16));
        emit(rTypeWord(Add, 16, 15, 13));
        emit(iTypeWord(Sw, 16, 11, 20));
        emit(iTypeWord(Beq, 0, 0, 1));
        emit(iTypeWord(Addi, 6, 0, 77));
        emit(iTypeWord(Addi, 17, 16, -1));
        emit(iTypeWord(Lw, 18, 11, 4));
        emit(iTypeWord(Sw, 18, 11, 24));
        emit(rTypeWord(Or, 19, 17, 18));
    endtask

    task automatic fillDataMemory();
        int i;
        seed = 32'hab48;
        for (i = 0; i < 64; i++) begin
            dmem[i[5:0]] = $random(seed);
            goldMem[i[5:0]] = dmem[i[5:0]];
        end
    endtask

    task automatic setGoldReg(regAddr dest, dataWord value);
        if (dest != '0) begin
            goldRegs[dest] = value;
            goldWritten[dest] = 1'b1;
        end
    endtask

    task automatic runGoldenModel();
        instrAddr pc;
        instrAddr nextPc;
        instrAddr endAddr;
        dataWord  ir;
        dataWord  follower;
        dataWord  a;
        dataWord  b;
        dataWord  imm;
        dataWord  addr;
        regAddr   rs;
        regAddr   rt;
        int       steps;
        int       r;
        for (r = 0; r < 32; r++) begin
            goldRegs[r[4:0]] = '0;
            goldWritten[r[4:0]] = 1'b0;
        end
        goldWritten[0] = 1'b1;
        pc = instrAddr'(`ResetAddr);
        endAddr = instrAddr'(progLen * 4);
        steps = 0;
        while (pc != endAddr) begin
            assert (steps < StepLimit)
                else abortWithMessage("golden model never reached the end of the program");
            steps++;
            ir       = imem[pc[7:2]];
            nextPc   = pc + 16'd4;
            follower = imem[nextPc[7:2]];
            rs       = ir[25:21];
            rt       = ir[20:16];
            a        = goldRegs[rs];
            b        = goldRegs[rt];
            imm      = {{16{ir[15]}}, ir[15:0]};
            addr     = a + imm;
            case (opcodeE'(ir[31:26]))
                RType: begin
                    case (functE'(ir[5:0]))
                        Add: setGoldReg(ir[15:11], a + b);
                        Sub: setGoldReg(ir[15:11], a - b);
                        And: setGoldReg(ir[15:11], a & b);
                        Or:  setGoldReg(ir[15:11], a | b);
                        Slt: setGoldReg(ir[15:11], {31'd0, $signed(a) < $signed(b)});
                        default: ;
                    endcase
                end
                Addi: setGoldReg(rt, addr);
                Lw: begin
                    setGoldReg(rt, goldMem[addr[7:2]]);
                    // Next instruction reads the loaded register
                    if (rt != '0 && (follower[25:21] == rt || follower[20:16] == rt)) begin
                        expStalls++;
                    end
                end
                Sw: begin
                    goldMem[addr[7:2]] = b;
                    expStoreAddr.push_back(addr[15:0]);
                    expStoreData.push_back(b);
                end
                Beq: begin
                    if (a == b) begin
                        nextPc = nextPc + instrAddr'(imm << 2);
                        expTargets.push_back(nextPc);
                    end
                end
                default: ;
            endcase
            pc = nextPc;
        end
    endtask

    // ----------------------------------------
    // Monitors
    // ----------------------------------------

    always @(negedge Clock) begin
        if (nReset) begin
            if (MemWrite) begin
                assert (storeIdx < expStoreAddr.size())
                    else abortWithMessage("store issued beyond the expected list");
                assert (MemAddr == expStoreAddr[storeIdx])
                    else mismatch("store address", dataWord'(expStoreAddr[storeIdx]),
                                  dataWord'(MemAddr));
                assert (WriteData == expStoreData[storeIdx])
                    else mismatch("store data", expStoreData[storeIdx], WriteData);
                storeIdx++;
            end
            // PC holds the branch target one cycle after JBFlush
            if (jbPending) begin
                assert (!JBFlush)
                    else abortWithMessage("JBFlush stayed high for more than one cycle");
                assert (InstrAddr == expTargets[jbCount - 1])
                    else mismatch("branch target", dataWord'(expTargets[jbCount - 1]),
                                  dataWord'(InstrAddr));
            end
            if (JBFlush) begin
                assert (jbCount < expTargets.size())
                    else abortWithMessage("JBFlush raised on a branch that is not taken");
                jbCount++;
            end
            jbPending = JBFlush;
            if (!nStall) begin
                assert (!stallPending)
                    else abortWithMessage("nStall stayed low for more than one cycle");
                stallCycles++;
            end
            stallPending = !nStall;
        end
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------

    task automatic applyReset();
        int cycle;
        for (cycle = 0; cycle < ResetCycles; cycle++) begin
            @(posedge Clock);
            if (cycle == ResetCycles - 1) begin
                nReset <= 1'b1;
            end
            @(negedge Clock);
            assert (!MemWrite && !MemRead && !JBFlush && nStall)
                else abortWithMessage("control outputs not idle during or right after reset");
            assert (InstrAddr == instrAddr'(`ResetAddr))
                else mismatch("reset InstrAddr", dataWord'(`ResetAddr), dataWord'(InstrAddr));
        end
    endtask

    task automatic waitProgramEnd(instrAddr doneAddr);
        int cycles;
        cycles = 0;
        while (InstrAddr != doneAddr) begin
            @(negedge Clock);
            cycles++;
            assert (cycles <= WaitLimit)
                else abortWithMessage("timed out waiting for the program to finish");
        end
    endtask

    task automatic compareRegisters();
        int r;
        for (r = 0; r < 32; r++) begin
            if (goldWritten[r[4:0]]) begin
                @(posedge Clock);
                RegAddr <= r[4:0];
                @(negedge Clock);
                assert (RegData == goldRegs[r[4:0]])
                    else mismatch($sformatf("register r%0d", r), goldRegs[r[4:0]], RegData);
            end
        end
    endtask

    initial begin
        buildProgram();
        fillDataMemory();
        runGoldenModel();
        applyReset();
        // Last instruction has left writeback six fetches later
        waitProgramEnd(instrAddr'(progLen * 4 + 24));
        compareRegisters();
        assert (storeIdx == expStoreAddr.size())
            else mismatch("store count", dataWord'(expStoreAddr.size()), dataWord'(storeIdx));
        assert (jbCount == expTargets.size())
            else mismatch("taken branch count", dataWord'(expTargets.size()), dataWord'(jbCount));
        assert (stallCycles == expStalls)
            else mismatch("load-use stall count", dataWord'(expStalls), dataWord'(stallCycles));
        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- processor.sv
`timescale 1ns/1ps

module processor (
    input  logic             Clock,
    input  logic             nReset,
    output isaPkg::instrAddr InstrAddr,
    input  isaPkg::dataWord  InstrMem,
    output isaPkg::instrAddr MemAddr,
    output logic             MemRead,
    output logic             MemWrite,
    output isaPkg::dataWord  WriteData,
    input  isaPkg::dataWord  MemData,
    input  isaPkg::regAddr   RegAddr,
    output isaPkg::dataWord  RegData,
    output logic             nStall,
    output logic             JBFlush
);

    import isaPkg::*;
    import pipePkg::*;

    logic       stall;
    logic       flush;
    fwdSelE     fwdA;
    fwdSelE     fwdB;
    instrAddr   branchTarget;
    dataWord    instr;
    instrAddr   instrPc;
    regAddr     rsAddr;
    regAddr     rtAddr;
    decodeExecT dex;
    executeMemT exm;
    memWbT      mwb;
    logic       writeEn;
    regAddr     writeAddr;
    dataWord    wbData;

    assign nStall = ~stall;

    fetchStage fetch (
        .Clock(Clock), .nReset(nReset),
        .stall(stall), .flush(flush),
        .branchTaken(JBFlush), .branchTarget(branchTarget),
        .InstrMem(InstrMem), .InstrAddr(InstrAddr),
        .instr(instr), .instrPc(instrPc)
    );

    decodeStage decode (
        .Clock(Clock), .nReset(nReset),
        .instr(instr), .instrPc(instrPc),
        .stall(stall), .flush(flush),
        .rsAddr(rsAddr), .rtAddr(rtAddr), .dex(dex),
        .writeEn(writeEn), .writeAddr(writeAddr), .writeData(wbData),
        .RegAddr(RegAddr), .RegData(RegData)
    );

    executeStage execute (
        .Clock(Clock), .nReset(nReset),
        .dex(dex), .fwdA(fwdA), .fwdB(fwdB), .wbData(wbData),
        .branchTaken(JBFlush), .branchTarget(branchTarget), .exm(exm)
    );

    hazardUnit hazard (
        .Clock(Clock), .nReset(nReset),
        .dex(dex), .exm(exm), .mwb(mwb),
        .rsAddr(rsAddr), .rtAddr(rtAddr), .branchTaken(JBFlush),
        .fwdA(fwdA), .fwdB(fwdB), .stall(stall), .flush(flush)
    );

    memoryStage memory (
        .Clock(Clock), .nReset(nReset),
        .exm(exm), .MemData(MemData),
        .MemAddr(MemAddr), .MemRead(MemRead), .MemWrite(MemWrite),
        .WriteData(WriteData), .mwb(mwb),
        .writeEn(writeEn), .writeAddr(writeAddr), .wbData(wbData)
    );

endmodule

//--- memoryStage.sv
`timescale 1ns/1ps

module memoryStage (
    input  logic                Clock,
    input  logic                nReset,
    input  pipePkg::executeMemT exm,
    input  isaPkg::dataWord     MemData,
    output isaPkg::instrAddr    MemAddr,
    output logic                MemRead,
    output logic                MemWrite,
    output isaPkg::dataWord     WriteData,
    output pipePkg::memWbT      mwb,
    output logic                writeEn,
    output isaPkg::regAddr      writeAddr,
    output isaPkg::dataWord     wbData
);

    import isaPkg::*;

    // Memory port, synchronous read
    assign MemAddr   = instrAddr'(exm.aluResult);
    assign MemRead   = exm.memRead;
    assign MemWrite  = exm.memWrite;
    assign WriteData = exm.storeData;

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            mwb <= '0;
        end else begin
            mwb.aluResult <= exm.aluResult;
            mwb.destAddr  <= exm.destAddr;
            mwb.regWrite  <= exm.regWrite;
            mwb.memToReg  <= exm.memRead;
        end
    end

    // ----------------------------------------
    // Writeback
    // ----------------------------------------

    // Load data arrives the cycle after MemRead
    assign wbData    = mwb.memToReg ? MemData : mwb.aluResult;
    assign writeEn   = mwb.regWrite;
    assign writeAddr = mwb.destAddr;

endmodule

//--- hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
    input  logic                Clock,
    input  logic                nReset,
    input  pipePkg::decodeExecT dex,
    input  pipePkg::executeMemT exm,
    input  pipePkg::memWbT      mwb,
    input  isaPkg::regAddr      rsAddr,
    input  isaPkg::regAddr      rtAddr,
    input  logic                branchTaken,
    output pipePkg::fwdSelE     fwdA,
    output pipePkg::fwdSelE     fwdB,
    output logic                stall,
    output logic                flush
);

    import isaPkg::*;
    import pipePkg::*;

    logic rsHit;
    logic rtHit;

    // Newest producer wins
    function automatic fwdSelE pickSource(regAddr src, executeMemT memStage, memWbT wbStage);
        if (src == '0) begin
            return FromRegs;
        end
        if (memStage.regWrite && memStage.destAddr == src) begin
            return FromMem;
        end
        if (wbStage.regWrite && wbStage.destAddr == src) begin
            return FromWb;
        end
        return FromRegs;
    endfunction

    assign fwdA = pickSource(dex.rsAddr, exm, mwb);
    assign fwdB = pickSource(dex.rtAddr, exm, mwb);

    // Load in execute feeding the instruction in decode
    assign rsHit = (rsAddr != '0) && (rsAddr == dex.destAddr);
    assign rtHit = (rtAddr != '0) && (rtAddr == dex.destAddr);
    assign stall = dex.memRead && dex.regWrite && (rsHit || rtHit);

    assign flush = branchTaken;

    // A load-use stall is one cycle and never meets a flush
    assert property (@(posedge Clock) disable iff (!nReset)
        stall |-> !flush ##1 !stall)
        else $error("stall overlaps a flush or lasts too long");

endmodule

//--- executeStage.sv
`timescale 1ns/1ps

module executeStage (
    input  logic                Clock,
    input  logic                nReset,
    input  pipePkg::decodeExecT dex,
    input  pipePkg::fwdSelE     fwdA,
    input  pipePkg::fwdSelE     fwdB,
    input  isaPkg::dataWord     wbData,
    output logic                branchTaken,
    output isaPkg::instrAddr    branchTarget,
    output pipePkg::executeMemT exm
);

    import isaPkg::*;
    import pipePkg::*;

    dataWord  opA;
    dataWord  opB;
    dataWord  aluB;
    dataWord  aluResult;
    instrAddr nextPc;

    // ----------------------------------------
    // Operand forwarding
    // ----------------------------------------

    always_comb begin
        case (fwdA)
            FromMem: opA = exm.aluResult;
            FromWb:  opA = wbData;
            default: opA = dex.rsData;
        endcase
        case (fwdB)
            FromMem: opB = exm.aluResult;
            FromWb:  opB = wbData;
            default: opB = dex.rtData;
        endcase
    end

    assign aluB = dex.aluSrc ? dex.imm : opB;

    always_comb begin
        case (dex.aluOp)
            AluSub:  aluResult = opA - aluB;
            AluAnd:  aluResult = opA & aluB;
            AluOr:   aluResult = opA | aluB;
            AluSlt:  aluResult = dataWord'($signed(opA) < $signed(aluB));
            default: aluResult = opA + aluB;
        endcase
    end

    // Branch resolves here with no delay slot
    assign nextPc       = dex.instrPc + instrAddr'(4);
    assign branchTarget = nextPc + instrAddr'(dex.imm << 2);
    assign branchTaken  = dex.valid && dex.branch && (opA == opB);

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            exm <= '0;
        end else begin
            exm.aluResult <= aluResult;
            exm.storeData <= opB;
            exm.destAddr  <= dex.destAddr;
            exm.regWrite  <= dex.regWrite;
            exm.memRead   <= dex.memRead;
            exm.memWrite  <= dex.memWrite;
        end
    end

    // The flush leaves a bubble behind a taken branch
    assert property (@(posedge Clock) disable iff (!nReset)
        branchTaken |=> !dex.valid)
        else $error("instruction behind a taken branch was not flushed");

endmodule

//--- decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
    input  logic               Clock,
    input  logic               nReset,
    input  isaPkg::dataWord    instr,
    input  isaPkg::instrAddr   instrPc,
    input  logic               stall,
    input  logic               flush,
    output isaPkg::regAddr     rsAddr,
    output isaPkg::regAddr     rtAddr,
    output pipePkg::decodeExecT dex,
    input  logic               writeEn,
    input  isaPkg::regAddr     writeAddr,
    input  isaPkg::dataWord    writeData,
    input  isaPkg::regAddr     RegAddr,
    output isaPkg::dataWord    RegData
);

    import isaPkg::*;
    import pipePkg::*;

    opcodeE     opcode;
    functE      funct;
    regAddr     rdAddr;
    dataWord    rsData;
    dataWord    rtData;
    decodeExecT nextDex;

    assign opcode = opcodeE'(instr[31:26]);
    assign funct  = functE'(instr[5:0]);
    assign rsAddr = instr[25:21];
    assign rtAddr = instr[20:16];
    assign rdAddr = instr[15:11];

    registerFile regFile (
        .Clock     (Clock),
        .nReset    (nReset),
        .rsAddr    (rsAddr),
        .rtAddr    (rtAddr),
        .RegAddr   (RegAddr),
        .rsData    (rsData),
        .rtData    (rtData),
        .RegData   (RegData),
        .writeEn   (writeEn),
        .writeAddr (writeAddr),
        .writeData (writeData)
    );

    // ----------------------------------------
    // Control decode
    // ----------------------------------------

    always_comb begin
        nextDex          = '0;
        nextDex.rsData   = rsData;
        nextDex.rtData   = rtData;
        nextDex.rsAddr   = rsAddr;
        nextDex.rtAddr   = rtAddr;
        nextDex.imm      = {{16{instr[15]}}, instr[15:0]};
        nextDex.instrPc  = instrPc;
        nextDex.aluOp    = AluAdd;
        nextDex.destAddr = rtAddr;
        case (opcode)
            RType: begin
                nextDex.destAddr = rdAddr;
                nextDex.regWrite = 1'b1;
                nextDex.valid    = 1'b1;
                case (funct)
                    Add: nextDex.aluOp = AluAdd;
                    Sub: nextDex.aluOp = AluSub;
                    And: nextDex.aluOp = AluAnd;
                    Or:  nextDex.aluOp = AluOr;
                    Slt: nextDex.aluOp = AluSlt;
                    default: begin
                        nextDex.regWrite = 1'b0;
                        nextDex.valid    = 1'b0;
                    end
                endcase
            end
            Addi: begin
                nextDex.aluSrc   = 1'b1;
                nextDex.regWrite = 1'b1;
                nextDex.valid    = 1'b1;
            end
            Lw: begin
                nextDex.aluSrc   = 1'b1;
                nextDex.regWrite = 1'b1;
                nextDex.memRead  = 1'b1;
                nextDex.valid    = 1'b1;
            end
            Sw: begin
                nextDex.aluSrc   = 1'b1;
                nextDex.memWrite = 1'b1;
                nextDex.valid    = 1'b1;
            end
            Beq: begin
                nextDex.aluOp  = AluSub;
                nextDex.branch = 1'b1;
                nextDex.valid  = 1'b1;
            end
            default: nextDex.valid = 1'b0;
        endcase
        // r0 is never a real destination
        if (nextDex.destAddr == '0) begin
            nextDex.regWrite = 1'b0;
        end
    end

    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            dex <= '0;
        end else if (stall || flush) begin
            dex <= '0;
        end else begin
            dex <= nextDex;
        end
    end

endmodule

//--- registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input  logic             Clock,
    input  logic             nReset,
    input  isaPkg::regAddr   rsAddr,
    input  isaPkg::regAddr   rtAddr,
    input  isaPkg::regAddr   RegAddr,
    output isaPkg::dataWord  rsData,
    output isaPkg::dataWord  rtData,
    output isaPkg::dataWord  RegData,
    input  logic             writeEn,
    input  isaPkg::regAddr   writeAddr,
    input  isaPkg::dataWord  writeData
);

    import isaPkg::*;

    dataWord regs [32];

    always_ff @(posedge Clock) begin
        if (writeEn && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Writeback value bypasses the array in the same cycle
    assign rsData = (rsAddr == '0) ? '0 :
                    (writeEn && writeAddr == rsAddr) ? writeData : regs[rsAddr];
    assign rtData = (rtAddr == '0) ? '0 :
                    (writeEn && writeAddr == rtAddr) ? writeData : regs[rtAddr];

    // Debug read
    assign RegData = (RegAddr == '0) ? '0 : regs[RegAddr];

    // Decode never lets a write to r0 reach writeback
    assert property (@(posedge Clock) disable iff (!nReset)
        writeEn |-> writeAddr != '0)
        else $error("register file write to r0");

endmodule

//--- fetchStage.sv
`timescale 1ns/1ps
`include "pipeline_macros.svh"

module fetchStage (
    input  logic              Clock,
    input  logic              nReset,
    input  logic              stall,
    input  logic              flush,
    input  logic              branchTaken,
    input  isaPkg::instrAddr  branchTarget,
    input  isaPkg::dataWord   InstrMem,
    output isaPkg::instrAddr  InstrAddr,
    output isaPkg::dataWord   instr,
    output isaPkg::instrAddr  instrPc
);

    import isaPkg::*;

    instrAddr pc;

    assign InstrAddr = pc;

    // Branch redirect wins over a held PC
    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            pc <= instrAddr'(`ResetAddr);
        end else if (branchTaken) begin
            pc <= branchTarget;
        end else if (!stall) begin
            pc <= pc + instrAddr'(4);
        end
    end

    // Fetch/decode register, zero word acts as a bubble
    always_ff @(posedge Clock or negedge nReset) begin
        if (!nReset) begin
            instr   <= '0;
            instrPc <= '0;
        end else if (flush) begin
            instr   <= '0;
            instrPc <= pc;
        end else if (!stall) begin
            instr   <= InstrMem;
            instrPc <= pc;
        end
    end

endmodule

//--- pipePkg.sv
`include "pipeline_macros.svh"

package pipePkg;

    import isaPkg::*;

    // ----------------------------------------
    // Stage registers
    // ----------------------------------------

    typedef struct packed {
        dataWord  rsData;
        dataWord  rtData;
        regAddr   rsAddr;
        regAddr   rtAddr;
        dataWord  imm;
        regAddr   destAddr;
        instrAddr instrPc;
        aluOpE    aluOp;
        logic     aluSrc;
        logic     regWrite;
        logic     memRead;
        logic     memWrite;
        logic     branch;
        logic     valid;
    } decodeExecT;

    typedef struct packed {
        dataWord aluResult;
        dataWord storeData;
        regAddr  destAddr;
        logic    regWrite;
        logic    memRead;
        logic    memWrite;
    } executeMemT;

    // memToReg picks the load data over the ALU result
    typedef struct packed {
        dataWord aluResult;
        regAddr  destAddr;
        logic    regWrite;
        logic    memToReg;
    } memWbT;

    // Operand source in execute
    typedef enum logic [1:0] {
        FromRegs = 2'd0,
        FromMem  = 2'd1,
        FromWb   = 2'd2
    } fwdSelE;

endpackage

//--- isaPkg.sv
`include "pipeline_macros.svh"

package isaPkg;

    typedef logic [`DataWidth-1:0] dataWord;
    typedef logic [`RegAddrWidth-1:0] regAddr;
    typedef logic [`InstrAddrWidth-1:0] instrAddr;

    // ----------------------------------------
    // Instruction fields
    // ----------------------------------------

    typedef enum logic [5:0] {
        RType = 6'd0,
        Beq   = 6'd4,
        Addi  = 6'd8,
        Lw    = 6'd35,
        Sw    = 6'd43
    } opcodeE;

    // R-type function field
    typedef enum logic [5:0] {
        Add = 6'd32,
        Sub = 6'd34,
        And = 6'd36,
        Or  = 6'd37,
        Slt = 6'd42
    } functE;

    // ----------------------------------------
    // ALU
    // ----------------------------------------

    typedef enum logic [2:0] {
        AluAdd = 3'd0,
        AluSub = 3'd1,
        AluAnd = 3'd2,
        AluOr  = 3'd3,
        AluSlt = 3'd4
    } aluOpE;

endpackage

//--- pipeline_macros.svh
`ifndef PIPELINE_MACROS_SVH
`define PIPELINE_MACROS_SVH

// Data path and instruction word width
`define DataWidth 32

// Register index width, 32 registers
`define RegAddrWidth 5

// Byte address width of both memories
`define InstrAddrWidth 16

// Fetch address after reset
`define ResetAddr 0

`endif
